//--- all.f
design/cpuPkg.sv
design/aluUnit.sv
design/regFile.sv
design/cpuControl.sv
design/processor.sv
tests/tbProcessor_assert.sv
tests/tbProcessor.sv

//--- runSim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbProcessor -f all.f -o tbProcessor

# keep running past assertion errors so the testbench prints its own verdict
./obj_dir/tbProcessor +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0

//--- tests/tbProcessor.sv
`timescale 1ns/100ps

module tbProcessor;
    import cpuPkg::*;

    localparam logic [dataWidth-1:0] startPc = '0;
    localparam logic [31:0] wordA = 32'h8000_00F0; // negative data word at 0x80
    localparam logic [31:0] wordB = 32'h0000_1234; // positive data word at 0x81
    localparam int memWords = 256;

    logic                 clk;
    logic                 arstN;
    memReqT               memReq;
    logic [dataWidth-1:0] memRData;
    logic                 memRdy;
    logic [dataWidth-1:0] outPort;
    logic                 halted;

    logic [31:0] mem [memWords]; // word addressed, the address is taken modulo 256
    logic [31:0] expOut [$];     // out values in the order the program must produce them
    logic [31:0] lastOut;
    int          outIdx;
    int          loadAddr;
    int          callRet;        // address of the word after jal
    int          errCount;
    int          delayLeft;
    logic        busy;           // a request has been seen and its delay is running
    int          cycles;

    processor #(.resetPc(startPc)) u_dut (
        .clk     (clk),
        .arstN   (arstN),
        .memReq  (memReq),
        .memRData(memRData),
        .memRdy  (memRdy),
        .outPort (outPort),
        .halted  (halted)
    );

    always #2 clk = ~clk; // 4 ns period

    function automatic instrT encode(input opcodeT op, input int ra, input int rb, input int imm);
        instrT i;
        i.opcode = op;
        i.ra     = ra[3:0];
        i.rb     = rb[3:0];
        i.imm    = imm[18:0]; // negative numbers keep their two's complement form
        return i;
    endfunction

    // rc lives in the top four immediate bits
    function automatic instrT regForm(input opcodeT op, input int ra, input int rb, input int rc);
        return encode(op, ra, rb, rc << 15);
    endfunction

    // the condition sits in rc[1:0] and the offset keeps 15 bits
    function automatic instrT branchIf(input brCondT cond, input int ra, input int offset);
        return encode(opBr, ra, 0, (int'(cond) << 15) | (offset & 32'h7FFF));
    endfunction

    task automatic put(input instrT i);
        mem[loadAddr] = i;
        loadAddr++;
    endtask

    // ALU instruction, then an out of its destination register
    task automatic putAndOut(input instrT i);
        put(i);
        put(encode(opOut, int'(i.ra), 0, 0));
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < memWords; i++) begin
            mem[i] = {16'hA5C3, 8'(i), 8'(~i)}; // unused words still differ per address
        end
        mem[8'h80] = wordA;
        mem[8'h81] = wordB;
        mem[8'h82] = 32'd5;
        loadAddr = 0;
        put(encode(opLd, 1, 0, 'h80));        // R0 based loads
        put(encode(opLd, 2, 0, 'h81));
        put(encode(opAddi, 3, 0, 'h80));
        put(encode(opLd, 4, 3, 2));           // register relative, r4 becomes 5
        put(encode(opOut, 4, 0, 0));
        putAndOut(regForm(opAdd, 5, 1, 2));
        putAndOut(regForm(opSub, 5, 2, 4));
        putAndOut(regForm(opAnd, 5, 1, 2));
        putAndOut(regForm(opOr, 5, 1, 2));
        putAndOut(encode(opAddi, 5, 2, -16));
        putAndOut(encode(opAndi, 5, 1, 'hFF));
        putAndOut(encode(opOri, 5, 2, 'h30000));
        putAndOut(encode(opNeg, 5, 2, 0));
        putAndOut(encode(opNot, 5, 1, 0));
        putAndOut(regForm(opShl, 5, 2, 4));
        putAndOut(regForm(opShr, 5, 1, 4));
        putAndOut(regForm(opSra, 5, 1, 4));
        putAndOut(regForm(opRol, 5, 1, 4));
        putAndOut(regForm(opRor, 5, 2, 4));
        put(encode(opSt, 5, 3, 'h10));        // lands at 0x90
        put(encode(opSt, 1, 0, 'h91));
        put(encode(opAddi, 6, 0, 'h111));
        put(branchIf(brZero, 6, 1));          // not taken
        put(encode(opOut, 6, 0, 0));
        put(branchIf(brNonzero, 6, 1));       // taken, so the next out is skipped
        put(encode(opOut, 1, 0, 0));
        put(branchIf(brPositive, 1, 1));      // r1 is negative, not taken
        put(encode(opOut, 2, 0, 0));
        put(branchIf(brNegative, 1, 1));      // taken
        put(encode(opOut, 1, 0, 0));
        put(branchIf(brZero, 0, 1));          // taken
        put(encode(opOut, 1, 0, 0));
        put(branchIf(brNegative, 2, 1));      // not taken
        put(encode(opOut, 4, 0, 0));
        put(branchIf(brPositive, 2, 1));      // taken
        put(encode(opOut, 1, 0, 0));
        put(branchIf(brNonzero, 0, 1));       // not taken
        put(encode(opOut, 3, 0, 0));
        put(encode(opAddi, 7, 0, 'hC0));
        put(encode(opJal, 7, 0, 0));
        callRet = loadAddr;
        put(encode(opOut, int'(linkReg), 0, 0));
        put(encode(opSt, int'(linkReg), 0, 'h92));
        put(encode(opHlt, 0, 0, 0));
        loadAddr = 'hC0;                      // subroutine far from the caller
        put(regForm(opAdd, 9, 2, 2));
        put(encode(opOut, 9, 0, 0));
        put(encode(opJr, int'(linkReg), 0, 0));
        expOut = '{32'd5, wordA + wordB, wordB - 32'd5, wordA & wordB, wordA | wordB,
                   wordB - 32'd16, wordA & 32'hFF, wordB | 32'h30000, -wordB, ~wordA,
                   wordB << 5, wordA >> 5, {{5{wordA[31]}}, wordA[31:5]},
                   (wordA << 5) | (wordA >> 27), (wordB >> 5) | (wordB << 27),
                   32'h111, wordB, 32'd5, 32'h80, wordB + wordB, 32'(callRet)};
    endtask

    // memory model: each request waits 0 to 3 cycles, memRdy drops after the completing edge
    always @(negedge clk) begin
        if (!arstN) begin
            memRdy = 1'b0;
            busy   = 1'b0;
        end else if (memRdy) begin
            memRdy = 1'b0;
            busy   = 1'b0;
        end else if (memReq.rd || memReq.wr) begin
            if (!busy) begin
                busy      = 1'b1;
                delayLeft = $urandom % 4;
            end
            if (delayLeft == 0) begin
                if (memReq.wr) begin
                    mem[memReq.addr[7:0]] = memReq.wData;
                end else begin
                    memRData = mem[memReq.addr[7:0]];
                end
                memRdy = 1'b1;
            end else begin
                delayLeft--;
            end
        end
    end

    // every change of outPort is compared with the next expected value
    always @(negedge clk) begin
        if (arstN && (outPort !== lastOut)) begin
            if (outIdx < expOut.size()) begin
                checkValue($sformatf("outPort[%0d]", outIdx), outPort, expOut[outIdx]);
            end else begin
                $display("outPort changed more often than the program has out instructions");
                errCount++;
            end
            lastOut = outPort;
            outIdx++;
        end
    end

    initial begin
        void'($urandom(32'he0f03b28));
        clk      = 1'b0;
        arstN    = 1'b0;
        memRdy   = 1'b0;
        memRData = '0;
        lastOut  = '0;
        outIdx   = 0;
        errCount = 0;
        busy     = 1'b0;
        loadProgram();
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        checkValue("outPort", outPort, '0);
        cycles = 0;
        while (!halted && (cycles < 2000)) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout, halted did not rise within 2000 cycles");
            errCount++;
        end else begin
            repeat (5) @(negedge clk); // halted must hold and the bus stay quiet
            checkValue("mem[0x90]", mem[8'h90], (wordB >> 5) | (wordB << 27));
            checkValue("mem[0x91]", mem[8'h91], wordA);
            checkValue("mem[0x92]", mem[8'h92], 32'(callRet));
            checkValue("mem[0x80]", mem[8'h80], wordA);
            checkValue("out count", 32'(outIdx), 32'(expOut.size()));
        end
        $display("errors: %0d check failures, %0d assertion failures",
                 errCount, u_dut.u_assert.failCount);
        if ((errCount == 0) && (u_dut.u_assert.failCount == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tests/tbProcessor_assert.sv
`timescale 1ns/100ps

module tbProcessor_assert #(
    parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
    input logic           clk,
    input logic           arstN,
    input cpuPkg::memReqT memReq,
    input logic           memRdy,
    input logic           halted
);

    int failCount = 0; // summed into the closing line of the testbench

    // a request is a read or a write, never both at once
    rdWrExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(memReq.rd && memReq.wr))
        else begin
            failCount++;
            $error("memory read and write are high in the same cycle");
        end

    // back-pressure: the whole request is held until memRdy completes it
    reqHeld: assert property (@(posedge clk) disable iff (!arstN)
        (memReq.rd || memReq.wr) && !memRdy |=> $stable(memReq))
        else begin
            failCount++;
            $error("memory request changed while memRdy was low");
        end

    // a halted processor stays off the bus
    quietWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
        halted |-> !memReq.rd && !memReq.wr)
        else begin
            failCount++;
            $error("memory access after halted rose");
        end

    haltSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
        else begin
            failCount++;
            $error("halted dropped without a reset");
        end

    // the edge after release leaves the idle state, so the next cycle fetches from resetPc
    firstFetch: assert property (@(posedge clk)
        $rose(arstN) |=> memReq.rd && !memReq.wr && (memReq.addr == resetPc))
        else begin
            failCount++;
            $error("first request after reset is not a read at the start address");
        end

endmodule

bind processor tbProcessor_assert #(.resetPc(resetPc)) u_assert (
    .clk   (clk),
    .arstN (arstN),
    .memReq(memReq),
    .memRdy(memRdy),
    .halted(halted)
);

//--- design/processor.sv
`timescale 1ns/100ps

module processor #(
    parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
    input  logic                         clk,
    input  logic                         arstN,
    output cpuPkg::memReqT               memReq,
    input  logic [cpuPkg::dataWidth-1:0] memRData,
    input  logic                         memRdy,
    output logic [cpuPkg::dataWidth-1:0] outPort,
    output logic                         halted
);
    import cpuPkg::*;

    logic [3:0]           rdAddrA;   // register file read side
    logic [3:0]           rdAddrB;
    logic [dataWidth-1:0] rdDataA;
    logic [dataWidth-1:0] rdDataB;
    logic                 wrEn;      // register file write side, active in writeback
    logic [3:0]           wrAddr;
    logic [dataWidth-1:0] wrData;
    logic [dataWidth-1:0] aluA;
    logic [dataWidth-1:0] aluB;
    aluOpT                aluOp;
    logic [dataWidth-1:0] aluResult;

    cpuControl #(
        .resetPc(resetPc)
    ) u_control (
        .clk      (clk),
        .arstN    (arstN),
        .memReq   (memReq),
        .memRData (memRData),
        .memRdy   (memRdy),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .aluA     (aluA),
        .aluB     (aluB),
        .aluOp    (aluOp),
        .aluResult(aluResult),
        .outPort  (outPort),
        .halted   (halted)
    );

    regFile u_regFile (
        .clk    (clk),
        .arstN  (arstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    aluUnit u_alu (
        .a     (aluA),
        .b     (aluB),
        .op    (aluOp),
        .result(aluResult)
    );

endmodule

//--- design/cpuControl.sv
`timescale 1ns/100ps

module cpuControl #(
    parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0
) (
    input  logic                         clk,
    input  logic                         arstN,
    output cpuPkg::memReqT               memReq,
    input  logic [cpuPkg::dataWidth-1:0] memRData,
    input  logic                         memRdy,
    output logic [3:0]                   rdAddrA,
    output logic [3:0]                   rdAddrB,
    input  logic [cpuPkg::dataWidth-1:0] rdDataA,
    input  logic [cpuPkg::dataWidth-1:0] rdDataB,
    output logic                         wrEn,
    output logic [3:0]                   wrAddr,
    output logic [cpuPkg::dataWidth-1:0] wrData,
    output logic [cpuPkg::dataWidth-1:0] aluA,
    output logic [cpuPkg::dataWidth-1:0] aluB,
    output cpuPkg::aluOpT                aluOp,
    input  logic [cpuPkg::dataWidth-1:0] aluResult,
    output logic [cpuPkg::dataWidth-1:0] outPort,
    output logic                         halted
);
    import cpuPkg::*;

    typedef enum logic [2:0] {sIdle, sFetch, sExec, sMem, sWb, sHalt} stateT;

    stateT                state;
    logic [dataWidth-1:0] pc;
    instrT                ir;        // instruction being executed, loaded at the end of fetch
    logic [dataWidth-1:0] resultReg; // value waiting for the writeback cycle
    logic [dataWidth-1:0] pcNext;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] brOffset;
    brCondT               brCond;
    logic                 brTaken;
    logic                 writesReg; // ALU style instructions that end in writeback
    logic                 useImm;

    assign pcNext  = pc + dataWidth'(1);
    assign immExt  = {{(dataWidth - 19){ir.imm[18]}}, ir.imm};
    assign brOffset = {{(dataWidth - 15){ir.imm[14]}}, ir.imm[14:0]}; // shorter since rc holds the condition
    assign brCond  = brCondT'(ir.imm[16:15]);
    assign writesReg = ir.opcode inside {opAdd, opSub, opAnd, opOr, opShl, opShr, opSra, opRol,
                                         opRor, opAddi, opAndi, opOri, opNeg, opNot};
    assign useImm  = ir.opcode inside {opAddi, opAndi, opOri, opLd, opSt};

    // operand routing follows the instruction held in ir for its whole lifetime
    assign rdAddrA = (ir.opcode inside {opBr, opJal, opJr, opOut}) ? ir.ra : ir.rb;
    assign aluA    = rdDataA;
    assign aluB    = useImm ? immExt : rdDataB;

    always_comb begin
        case (ir.opcode)
            opSt:        rdAddrB = ir.ra;         // store data comes out of port B
            opNeg, opNot: rdAddrB = ir.rb;        // unary operations take their operand as b
            default:     rdAddrB = ir.imm[18:15]; // rc
        endcase
        case (ir.opcode)
            opSub:         aluOp = aluSub;
            opAnd, opAndi: aluOp = aluAnd;
            opOr, opOri:   aluOp = aluOr;
            opShl:         aluOp = aluShl;
            opShr:         aluOp = aluShr;
            opSra:         aluOp = aluSra;
            opRol:         aluOp = aluRol;
            opRor:         aluOp = aluRor;
            opNeg:         aluOp = aluNeg;
            opNot:         aluOp = aluNot;
            default:       aluOp = aluAdd; // add, addi and the ld and st address
        endcase
        case (brCond)
            brZero:     brTaken = (rdDataA == '0);
            brNonzero:  brTaken = (rdDataA != '0);
            brPositive: brTaken = !rdDataA[dataWidth-1] && (rdDataA != '0);
            default:    brTaken = rdDataA[dataWidth-1];
        endcase
    end

    // the request is decoded from the state and stays fixed while memRdy is low
    always_comb begin
        memReq = '0;
        case (state)
            sFetch: begin
                memReq.addr = pc;
                memReq.rd   = 1'b1;
            end
            sMem: begin
                memReq.addr  = aluResult;              // rb plus immediate, unchanged during the wait
                memReq.wData = rdDataB;
                memReq.rd    = (ir.opcode == opLd);
                memReq.wr    = (ir.opcode == opSt);
            end
            default: begin
                memReq = '0;
            end
        endcase
    end

    assign wrEn   = (state == sWb);
    assign wrAddr = (ir.opcode == opJal) ? linkReg : ir.ra;
    assign wrData = resultReg;
    assign halted = (state == sHalt);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= sIdle; // one quiet cycle before the first fetch
            pc      <= resetPc;
            outPort <= '0;
        end else begin
            case (state)
                sIdle: state <= sFetch;
                sFetch: begin
                    if (memRdy) begin
                        state <= sExec;
                    end
                end
                sExec: begin
                    pc    <= pcNext; // default flow, overridden by jumps and taken branches
                    state <= writesReg ? sWb : sFetch;
                    case (ir.opcode)
                        opLd, opSt: state <= sMem;
                        opBr: begin
                            if (brTaken) begin
                                pc <= pcNext + brOffset;
                            end
                        end
                        opJal: begin
                            pc    <= rdDataA;
                            state <= sWb; // return address goes to the link register
                        end
                        opJr:  pc <= rdDataA;
                        opOut: outPort <= rdDataA;
                        opHlt: state <= sHalt;
                        default: ; // nop and unknown opcodes just advance
                    endcase
                end
                sMem: begin
                    if (memRdy) begin
                        state <= (ir.opcode == opLd) ? sWb : sFetch;
                    end
                end
                sWb:     state <= sFetch;
                sHalt:   state <= sHalt; // only reset leaves this state
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == sFetch) && memRdy) begin
            ir <= instrT'(memRData);
        end
        if (state == sExec) begin
            resultReg <= (ir.opcode == opJal) ? pcNext : aluResult;
        end else if ((state == sMem) && memRdy) begin
            resultReg <= memRData; // load data, written back next cycle
        end
    end

endmodule

//--- design/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [3:0]                   rdAddrA,
    input  logic [3:0]                   rdAddrB,
    output logic [cpuPkg::dataWidth-1:0] rdDataA,
    output logic [cpuPkg::dataWidth-1:0] rdDataB,
    input  logic                         wrEn,
    input  logic [3:0]                   wrAddr,
    input  logic [cpuPkg::dataWidth-1:0] wrData
);

    logic [cpuPkg::dataWidth-1:0] regs [16]; // architectural registers, the program sees them zeroed

    // reads are combinational so the control unit sees operands in the same cycle
    assign rdDataA = (rdAddrA == 4'd0) ? '0 : regs[rdAddrA]; // R0 always reads zero
    assign rdDataB = (rdAddrB == 4'd0) ? '0 : regs[rdAddrB];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 4'd0)) begin
            regs[wrAddr] <= wrData; // writes aimed at R0 are simply lost
        end
    end

endmodule

//--- design/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  cpuPkg::aluOpT                op,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    localparam int shW = $clog2(dataWidth); // shift amount bits, five for a 32 bit word

    logic [shW-1:0] shAmt;   // shift and rotate distance, b modulo the word width
    logic [shW:0]   rotBack; // the opposite shift that completes a rotate

    always_comb begin
        shAmt   = b[shW-1:0];
        rotBack = (shW + 1)'(dataWidth) - {1'b0, shAmt}; // a zero distance gives a full word shift
        case (op)
            aluAdd: begin
                result = a + b; // also forms load and store addresses
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluShl: begin
                result = a << shAmt;
            end
            aluShr: begin
                result = a >> shAmt; // zero fill from the top
            end
            aluSra: begin
                result = $signed(a) >>> shAmt; // the sign bit is copied down
            end
            aluRol: begin
                result = (a << shAmt) | (a >> rotBack); // shifting by a full word yields zero
            end
            aluRor: begin
                result = (a >> shAmt) | (a << rotBack);
            end
            aluNeg: begin
                result = '0 - b; // the unary operations work on b only
            end
            aluNot: begin
                result = ~b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth = 32;         // one word of data and one word address
    localparam logic [3:0] linkReg = 4'd8; // jal leaves its return address in this register

    // one value per supported instruction, numbered in the order listed
    typedef enum logic [4:0] {
        opNop,
        opAdd,
        opSub,
        opAnd,
        opOr,
        opShl,
        opShr,
        opSra,
        opRol,
        opRor,
        opAddi,
        opAndi,
        opOri,
        opNeg,
        opNot,
        opLd,
        opSt,
        opBr,
        opJal,
        opJr,
        opOut,
        opHlt
    } opcodeT;

    // the rc register number occupies imm[18:15] when an instruction needs it
    // a branch keeps its condition in rc[1:0], which is imm[16:15]
    // so its signed word offset is limited to imm[14:0]
    typedef struct packed {
        opcodeT      opcode; // bits 31:27
        logic [3:0]  ra;     // destination, store source or branch test register
        logic [3:0]  rb;     // first source or address base
        logic [18:0] imm;    // sign extended before use
    } instrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluShl,
        aluShr,
        aluSra,
        aluRol,
        aluRor,
        aluNeg,
        aluNot
    } aluOpT;

    // positive means greater than zero, so a zero register takes neither sign branch
    typedef enum logic [1:0] {
        brZero,
        brNonzero,
        brPositive,
        brNegative
    } brCondT;

    typedef struct packed {
        logic [dataWidth-1:0] addr;  // word address
        logic [dataWidth-1:0] wData; // only meaningful while wr is high
        logic                 rd;
        logic                 wr;
    } memReqT;

endpackage
